//--- aluExec.sv
`default_nettype none
`timescale 1ns/10ps

module aluExec (
    input  wire                  clk,
    input  wire                  en,
    input  wire cpuPkg::aluOp_t  op,
    input  wire cpuPkg::word_t   left,
    input  wire cpuPkg::word_t   right,
    input  wire cpuPkg::word_t   addend,
    output cpuPkg::word_t        result
);

    localparam int W = cpuPkg::DATA_W;

    cpuPkg::word_t opResult;
    logic          lessThan;
    logic          greaterThan;

    assign lessThan    = $signed(left) < $signed(right);
    assign greaterThan = $signed(left) > $signed(right);

    always_comb begin
        case (op)
            cpuPkg::ALU_OR:   opResult = left | right;
            cpuPkg::ALU_AND:  opResult = left & right;
            cpuPkg::ALU_ADD:  opResult = left + right;
            cpuPkg::ALU_MUL:  opResult = left * right;  // Low word only
            cpuPkg::ALU_SHL:  opResult = left << right;
            cpuPkg::ALU_LT:   opResult = {W{lessThan}};
            cpuPkg::ALU_EQ:   opResult = {W{left == right}};
            cpuPkg::ALU_GT:   opResult = {W{greaterThan}};
            cpuPkg::ALU_ANDN: opResult = left & ~right;
            cpuPkg::ALU_XOR:  opResult = left ^ right;
            cpuPkg::ALU_SUB:  opResult = left - right;
            cpuPkg::ALU_XNOR: opResult = left ^~ right;
            cpuPkg::ALU_SHR:  opResult = left >> right; // Zero fill
            cpuPkg::ALU_NE:   opResult = {W{left != right}};
            default:          opResult = '0;            // Addend passes alone on reserved codes
        endcase
    end

    // Captured at the end of phase A
    always_ff @(posedge clk) begin
        if (en) begin
            result <= opResult + addend;
        end
    end

endmodule

`default_nettype wire

//--- coreSequencer.sv
`default_nettype none
`timescale 1ns/10ps

module coreSequencer #(
    parameter cpuPkg::word_t RESET_VECTOR = cpuPkg::DEFAULT_RESET_VECTOR
) (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 en,
    input  wire                 illegal,
    input  wire                 branch,
    input  wire cpuPkg::word_t  target,
    output cpuPkg::word_t       pc,
    output logic                execEn,
    output logic                commit,
    output logic                halt
);

    logic [1:0] phase;                              // Bit 0 is A, bit 1 is B
    logic [1:0] phaseLive;                          // Enable shadow for phase
    logic [1:0] activePhase;

    assign activePhase = phase & phaseLive;

    assign execEn = en && activePhase[0];
    // Halt set in phase A cancels the following phase B
    assign commit = en && activePhase[1] && !halt;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            pc        <= RESET_VECTOR;
            halt      <= 1'b0;
            phase     <= 2'b10;
            phaseLive <= 2'b00;                     // One idle cycle before phase A
        end else if (en) begin
            phase     <= {phase[0], phase[1]};
            phaseLive <= {phaseLive[0], phase[1] & ~halt};

            if (execEn) begin
                halt <= halt | illegal;             // Sticky until reset
            end

            if (commit) begin
                pc <= branch ? target : pc + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- cpuPkg.sv
`default_nettype none

package cpuPkg;

    localparam int DATA_W    = 32;                  // Data and address width
    localparam int REG_IDX_W = 4;
    localparam int IMM_W     = 12;                  // Raw immediate field

    typedef logic [REG_IDX_W-1:0] regIdx_t;
    typedef logic [DATA_W-1:0]    word_t;

    // Encoding matches the op field of the instruction word
    typedef enum logic [3:0] {
        ALU_OR     = 4'd0,
        ALU_AND    = 4'd1,
        ALU_ADD    = 4'd2,
        ALU_MUL    = 4'd3,
        ALU_RSVD4  = 4'd4,                          // Reserved
        ALU_SHL    = 4'd5,
        ALU_LT     = 4'd6,                          // Signed
        ALU_EQ     = 4'd7,
        ALU_GT     = 4'd8,                          // Signed
        ALU_ANDN   = 4'd9,
        ALU_XOR    = 4'd10,
        ALU_SUB    = 4'd11,
        ALU_XNOR   = 4'd12,
        ALU_SHR    = 4'd13,                         // Logical
        ALU_NE     = 4'd14,
        ALU_RSVD15 = 4'd15                          // Reserved
    } aluOp_t;

    localparam regIdx_t REG_ZERO = 4'd0;            // Always reads zero
    localparam regIdx_t REG_PC   = 4'd15;           // Reads program counter plus one

    localparam word_t DEFAULT_RESET_VECTOR = 32'h0000_0100;

endpackage

`default_nettype wire

//--- decodeIf.sv
`default_nettype none
`timescale 1ns/10ps

interface decodeIf;

    cpuPkg::regIdx_t idxZ;                          // Destination
    cpuPkg::regIdx_t idxX;                          // Left operand
    cpuPkg::regIdx_t idxY;
    cpuPkg::aluOp_t  op;
    cpuPkg::word_t   imm;                           // Already sign-extended

    logic immRight;                                 // Immediate on the right
    logic storing;
    logic derefRhs;                                 // Result is a memory address
    logic branch;
    logic illegal;

    modport producer (
        output idxZ, idxX, idxY,
        output op,
        output imm,
        output immRight, storing, derefRhs,
        output branch, illegal
    );

    modport consumer (
        input idxZ, idxX, idxY,
        input op,
        input imm,
        input immRight, storing, derefRhs,
        input branch, illegal
    );

endinterface

`default_nettype wire

//--- insnDecode.sv
`default_nettype none
`timescale 1ns/10ps

module insnDecode (
    input wire cpuPkg::word_t insn,
    decodeIf.producer         dec
);

    localparam int EXT_W = cpuPkg::DATA_W - cpuPkg::IMM_W;

    logic                      storeBit;
    cpuPkg::regIdx_t           zField;
    logic [cpuPkg::IMM_W-1:0]  immField;

    assign storeBit = insn[29];
    assign zField   = insn[27:24];
    assign immField = insn[cpuPkg::IMM_W-1:0];

    assign dec.immRight = insn[30];
    assign dec.storing  = storeBit;
    assign dec.derefRhs = insn[28];
    assign dec.idxZ     = zField;
    assign dec.idxX     = insn[23:20];
    assign dec.idxY     = insn[19:16];
    assign dec.op       = cpuPkg::aluOp_t'(insn[15:12]);

    // Top bit of the field replicated upward
    assign dec.imm = {{EXT_W{immField[cpuPkg::IMM_W-1]}}, immField};

    assign dec.illegal = &insn;                     // All-ones word
    assign dec.branch  = (zField == cpuPkg::REG_PC) && !storeBit;

endmodule

`default_nettype wire

//--- regFile.sv
`default_nettype none
`timescale 1ns/10ps

module regFile (
    input  wire                   clk,
    input  wire                   writeEn,
    input  wire cpuPkg::regIdx_t  idxZ,
    input  wire cpuPkg::regIdx_t  idxX,
    input  wire cpuPkg::regIdx_t  idxY,
    input  wire cpuPkg::word_t    writeData,
    input  wire cpuPkg::word_t    pc,
    output cpuPkg::word_t         valueZ,
    output cpuPkg::word_t         valueX,
    output cpuPkg::word_t         valueY
);

    cpuPkg::word_t store [1:14];                    // Only the storage indices

    logic zIsStorage;

    // Shared by all three read ports
    function automatic cpuPkg::word_t readPort(input cpuPkg::regIdx_t idx);
        if (idx == cpuPkg::REG_ZERO)
            return '0;
        else if (idx == cpuPkg::REG_PC)
            return pc + 1'b1;
        else
            return store[idx];
    endfunction

    always_comb begin
        valueZ = readPort(idxZ);
        valueX = readPort(idxX);
        valueY = readPort(idxY);
    end

    assign zIsStorage = (idxZ != cpuPkg::REG_ZERO) && (idxZ != cpuPkg::REG_PC);

    always_ff @(posedge clk) begin
        if (writeEn && zIsStorage) begin
            store[idxZ] <= writeData;               // Writes to 0 and 15 vanish
        end
    end

endmodule

`default_nettype wire

//--- resultCommit.sv
`default_nettype none
`timescale 1ns/10ps

module resultCommit (
    decodeIf.consumer           dec,
    input  wire                 commit,
    input  wire cpuPkg::word_t  aluResult,
    input  wire cpuPkg::word_t  valueZ,
    input  wire cpuPkg::word_t  dReadData,
    output cpuPkg::word_t       dAddr,
    output cpuPkg::word_t       dWriteData,
    output cpuPkg::word_t       regWriteData,
    output logic                regWriteEn,
    output logic                dataWe
);

    // Address comes from the ALU when dereferencing, else from Z
    assign dAddr = dec.derefRhs ? aluResult : valueZ;

    // Store data is whichever side is not the address
    assign dWriteData = dec.derefRhs ? valueZ : aluResult;

    // Load brings memory in, otherwise the ALU value
    assign regWriteData = dec.derefRhs ? dReadData : aluResult;  // Also branch target

    assign dataWe     = commit && dec.storing;
    assign regWriteEn = commit && !dec.storing;

endmodule

`default_nettype wire

//--- tb.f
cpuPkg.sv
decodeIf.sv
insnDecode.sv
regFile.sv
aluExec.sv
resultCommit.sv
coreSequencer.sv
tenyrCore.sv
tbMemory.sv
tbTenyrCore.sv

//--- tbMemory.sv
`default_nettype none
`timescale 1ns/10ps

module tbMemory #(
    parameter int DEPTH  = 1024,
    parameter int ADDR_W = 10
) (
    input  wire                 clk,
    input  wire cpuPkg::word_t  iAddr,
    input  wire cpuPkg::word_t  dAddr,
    input  wire cpuPkg::word_t  dWriteData,
    input  wire                 dataWe,
    output cpuPkg::word_t       iData,
    output cpuPkg::word_t       dReadData
);

    cpuPkg::word_t mem [0:DEPTH-1];                 // Shared by both ports

    // Low address bits pick the word
    assign iData     = mem[iAddr[ADDR_W-1:0]];
    assign dReadData = mem[dAddr[ADDR_W-1:0]];

    always @(posedge clk) begin
        if (dataWe) begin
            mem[dAddr[ADDR_W-1:0]] <= dWriteData;
        end
    end

    // Backdoor port for program load
    task automatic writeWord(input int addr, input cpuPkg::word_t data);
        mem[addr[ADDR_W-1:0]] <= data;
    endtask

    function automatic cpuPkg::word_t readWord(input int addr);
        return mem[addr[ADDR_W-1:0]];
    endfunction

endmodule

`default_nettype wire

//--- tbTenyrCore.sv
`default_nettype none
`timescale 1ns/10ps

module tbTenyrCore;

    localparam cpuPkg::word_t RESET_VEC = cpuPkg::DEFAULT_RESET_VECTOR;
    localparam cpuPkg::word_t ALL_ONES  = 32'hFFFF_FFFF;    // Illegal word and true flag
    localparam int ALU_BUDGET = 120;
    localparam int RULE_BUDGET = 40;
    localparam int MEM_BUDGET = 30;
    localparam int BRANCH_BUDGET = 30;
    localparam int ENABLE_BUDGET = 30;
    localparam int CYCLE_LIMIT = 2 * (ALU_BUDGET + RULE_BUDGET + MEM_BUDGET + BRANCH_BUDGET
                                      + ENABLE_BUDGET);

    logic          clk;
    logic          reset_n;
    logic          en;
    cpuPkg::word_t iAddr;
    cpuPkg::word_t iData;
    cpuPkg::word_t dAddr;
    cpuPkg::word_t dReadData;
    cpuPkg::word_t dWriteData;
    logic          dataWe;
    logic          halt;

    int            errors = 0;
    int            checks = 0;
    int            cycleCount = 0;
    int            rngSeed;
    cpuPkg::word_t prog [$];                        // Program under construction

    tenyrCore #(.RESET_VECTOR(RESET_VEC)) tenyrCore_inst (
        .clk(clk), .reset_n(reset_n), .en(en), .iData(iData), .dReadData(dReadData),
        .iAddr(iAddr), .dAddr(dAddr), .dWriteData(dWriteData), .dataWe(dataWe), .halt(halt)
    );

    tbMemory tbMemory_inst (
        .clk(clk), .iAddr(iAddr), .dAddr(dAddr), .dWriteData(dWriteData),
        .dataWe(dataWe), .iData(iData), .dReadData(dReadData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= CYCLE_LIMIT) begin
            $display("Timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic cpuPkg::word_t encode(input bit immRight, input bit storing,
            input bit deref, input int z, input int x, input int y, input int op, input int imm);
        cpuPkg::word_t w;
        w = '0;
        w[30] = immRight;
        w[29] = storing;
        w[28] = deref;
        w[27:24] = z[3:0];
        w[23:20] = x[3:0];
        w[19:16] = y[3:0];
        w[15:12] = op[3:0];
        w[11:0] = imm[11:0];
        return w;
    endfunction

    function automatic cpuPkg::word_t signExtend(input int imm);
        return {{20{imm[11]}}, imm[11:0]};
    endfunction

    function automatic cpuPkg::word_t fillWord(input int addr);
        return {6'h2D, addr[9:0], 6'h12, addr[9:0]};        // Unique per word
    endfunction

    // Comparisons give all ones for true
    function automatic cpuPkg::word_t expectOp(input int op, input cpuPkg::word_t l,
            input cpuPkg::word_t r);
        case (op)
            0:  return l | r;
            1:  return l & r;
            2:  return l + r;
            3:  return l * r;
            5:  return l << r;
            6:  return ($signed(l) < $signed(r)) ? ALL_ONES : 0;
            7:  return (l == r) ? ALL_ONES : 0;
            8:  return ($signed(l) > $signed(r)) ? ALL_ONES : 0;
            9:  return l & ~r;
            10: return l ^ r;
            11: return l - r;
            12: return ~(l ^ r);
            13: return l >> r;
            14: return (l != r) ? ALL_ONES : 0;
            default: return 0;                      // Reserved codes leave the addend
        endcase
    endfunction

    task automatic checkWord(input string name, input cpuPkg::word_t expected,
            input cpuPkg::word_t actual);
        checks++;
        assert (actual === expected) else begin
            errors++;
            $display("FAIL at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic checkMem(input int addr, input cpuPkg::word_t expected);
        checkWord($sformatf("dataMem[%0h]", addr), expected, tbMemory_inst.readWord(addr));
    endtask

    task automatic putInsn(input cpuPkg::word_t w);
        prog.push_back(w);
    endtask

    // Builds a full word from 10, 11 and 11 bit chunks shifted by r13 holding 11
    task automatic loadConst(input int z, input cpuPkg::word_t value);
        putInsn(encode(0, 0, 0, z, 0, 0, 0, value[31:22]));
        putInsn(encode(0, 0, 0, z, z, 13, 5, value[21:11]));
        putInsn(encode(0, 0, 0, z, z, 13, 5, value[10:0]));
    endtask

    task automatic storeReg(input int z, input int addr);
        putInsn(encode(0, 1, 1, z, 0, 0, 0, addr));     // mem[addr] = Z
    endtask

    task automatic beginProgram();
        prog.delete();
        for (int i = 0; i < 1024; i++) begin
            tbMemory_inst.writeWord(i, fillWord(i));
        end
    endtask

    task automatic endProgram();
        prog.push_back(ALL_ONES);
        foreach (prog[i]) begin
            tbMemory_inst.writeWord(RESET_VEC + i, prog[i]);
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        reset_n <= 1'b0;
        en <= 1'b1;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    task automatic runToHalt(input int budget);
        int cycles;
        cycles = 0;
        while (!halt && cycles < budget) begin
            @(negedge clk);
            cycles++;
        end
        assert (halt) else begin
            errors++;
            $display("Program did not halt within %0d cycles at %0t ns", budget, $time);
        end
        checkWord("iAddr", RESET_VEC + prog.size() - 1, iAddr);   // Stopped on the illegal word
    endtask

    task automatic aluOperations();
        cpuPkg::word_t a;
        cpuPkg::word_t b;
        int immOp [16];
        int immExtra [3];
        beginProgram();
        a = $urandom();
        b = $urandom();
        for (int k = 0; k < 16; k++) begin
            immOp[k] = $urandom() & 'hFFF;
        end
        for (int k = 0; k < 3; k++) begin
            immExtra[k] = $urandom() & 'hFFF;
        end
        putInsn(encode(0, 0, 0, 13, 0, 0, 0, 11));
        loadConst(1, a);
        loadConst(2, b);
        putInsn(encode(1, 0, 0, 4, 2, 0, 1, 31));       // r4 = b & 31 with immediate right
        for (int op = 0; op < 16; op++) begin
            putInsn(encode(0, 0, 0, 3, 1, 2, op, immOp[op]));
            storeReg(3, 'h200 + op);
        end
        putInsn(encode(0, 0, 0, 3, 1, 4, 5, immExtra[0]));
        storeReg(3, 'h210);
        putInsn(encode(0, 0, 0, 3, 1, 4, 13, immExtra[1]));
        storeReg(3, 'h211);
        putInsn(encode(0, 0, 0, 3, 1, 1, 7, immExtra[2]));   // Equal operands
        storeReg(3, 'h212);
        endProgram();
        applyReset();
        runToHalt(ALU_BUDGET);
        for (int op = 0; op < 16; op++) begin
            checkMem('h200 + op, expectOp(op, a, b) + signExtend(immOp[op]));
        end
        checkMem('h210, expectOp(5, a, b & 31) + signExtend(immExtra[0]));
        checkMem('h211, expectOp(13, a, b & 31) + signExtend(immExtra[1]));
        checkMem('h212, expectOp(7, a, a) + signExtend(immExtra[2]));
    endtask

    task automatic operandRules();
        beginProgram();
        putInsn(encode(0, 0, 0, 1, 0, 0, 0, 100));
        putInsn(encode(0, 0, 0, 2, 0, 0, 0, -5));
        putInsn(encode(1, 0, 0, 3, 1, 2, 11, 7));       // r1 - imm + r2
        putInsn(encode(0, 0, 0, 5, 1, 2, 11, 7));       // r1 - r2 + imm
        putInsn(encode(0, 0, 0, 0, 0, 0, 0, 55));
        putInsn(encode(0, 0, 0, 6, 15, 0, 0, 0));       // Read of r15 at offset 5
        storeReg(2, 'h220);
        storeReg(3, 'h221);
        storeReg(5, 'h222);
        storeReg(0, 'h223);
        storeReg(6, 'h224);
        endProgram();
        applyReset();
        runToHalt(RULE_BUDGET);
        checkMem('h220, signExtend(-5));
        checkMem('h221, 32'd100 - 32'd7 + signExtend(-5));
        checkMem('h222, 32'd100 - signExtend(-5) + 32'd7);
        checkMem('h223, 32'd0);
        checkMem('h224, RESET_VEC + 5 + 1);
    endtask

    task automatic memoryPaths();
        cpuPkg::word_t loadVal;
        beginProgram();
        loadVal = $urandom();
        putInsn(encode(0, 0, 0, 1, 0, 0, 0, 'h230));
        putInsn(encode(0, 0, 0, 2, 0, 0, 0, 77));
        putInsn(encode(0, 1, 0, 1, 2, 0, 0, 5));        // Result to address in Z
        putInsn(encode(0, 1, 1, 2, 1, 0, 0, 1));        // Z to address from result
        putInsn(encode(0, 0, 1, 3, 0, 0, 0, 'h240));    // Load
        storeReg(3, 'h232);
        endProgram();
        tbMemory_inst.writeWord('h240, loadVal);
        applyReset();
        runToHalt(MEM_BUDGET);
        checkMem('h230, 32'd77 + 32'd5);
        checkMem('h231, 32'd77);
        checkMem('h232, loadVal);
    endtask

    task automatic branching();
        beginProgram();
        putInsn(encode(0, 0, 0, 15, 0, 0, 0, RESET_VEC + 3));
        storeReg(15, 'h250);
        storeReg(15, 'h251);
        putInsn(encode(0, 0, 0, 2, 0, 0, 0, 9));
        storeReg(2, 'h252);
        putInsn(encode(0, 0, 0, 15, 15, 0, 2, 1));      // Relative jump over one word
        storeReg(2, 'h253);
        storeReg(2, 'h254);
        endProgram();
        applyReset();
        runToHalt(BRANCH_BUDGET);
        checkMem('h250, fillWord('h250));
        checkMem('h251, fillWord('h251));
        checkMem('h252, 32'd9);
        checkMem('h253, fillWord('h253));
        checkMem('h254, 32'd9);
    endtask

    task automatic haltResetEnable();
        int enCycles;
        int steps;
        beginProgram();
        for (int k = 0; k < 4; k++) begin
            putInsn(encode(0, 0, 0, 1, 1, 0, 0, 1));
        end
        endProgram();
        applyReset();
        @(negedge clk);
        checkWord("iAddr", RESET_VEC, iAddr);
        checkWord("halt", 0, halt);
        checkWord("dataWe", 0, dataWe);
        enCycles = 0;
        for (int k = 0; k < 24; k++) begin
            @(posedge clk);
            if (en)
                enCycles++;                         // Edge seen with en high
            en <= (k < 5 || k > 8);
            @(negedge clk);
            steps = (enCycles > 0) ? (enCycles - 1) / 2 : 0;
            if (steps > 4)
                steps = 4;                          // Frozen on the illegal word
            checkWord("iAddr", RESET_VEC + steps, iAddr);
            checkWord("halt", enCycles >= 10, halt);
            checkWord("dataWe", 0, dataWe);         // No stores, illegal word writes nothing
        end
    endtask

    initial begin
        reset_n = 1'b0;
        en = 1'b0;
        rngSeed = 10;
        void'($urandom(rngSeed));
        aluOperations();
        operandRules();
        memoryPaths();
        branching();
        haltResetEnable();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tenyrCore.sv
`default_nettype none
`timescale 1ns/10ps

module tenyrCore #(
    parameter cpuPkg::word_t RESET_VECTOR = cpuPkg::DEFAULT_RESET_VECTOR
) (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 en,
    input  wire cpuPkg::word_t  iData,
    input  wire cpuPkg::word_t  dReadData,
    output cpuPkg::word_t       iAddr,
    output cpuPkg::word_t       dAddr,
    output cpuPkg::word_t       dWriteData,
    output logic                dataWe,
    output logic                halt
);

    decodeIf decBus ();

    cpuPkg::word_t valueZ;
    cpuPkg::word_t valueX;
    cpuPkg::word_t valueY;
    cpuPkg::word_t right;
    cpuPkg::word_t addend;
    cpuPkg::word_t aluResult;
    cpuPkg::word_t regWriteData;
    logic          regWriteEn;
    logic          execEn;
    logic          commit;

    // Instruction read straight from the memory output
    insnDecode insnDecode_inst (
        .insn (iData),
        .dec  (decBus.producer)
    );

    regFile regFile_inst (
        .clk       (clk),
        .writeEn   (regWriteEn),
        .idxZ      (decBus.idxZ),
        .idxX      (decBus.idxX),
        .idxY      (decBus.idxY),
        .writeData (regWriteData),
        .pc        (iAddr),
        .valueZ    (valueZ),
        .valueX    (valueX),
        .valueY    (valueY)
    );

    // Immediate and Y trade places
    assign right  = decBus.immRight ? decBus.imm : valueY;
    assign addend = decBus.immRight ? valueY     : decBus.imm;

    aluExec aluExec_inst (
        .clk    (clk),
        .en     (execEn),
        .op     (decBus.op),
        .left   (valueX),
        .right  (right),
        .addend (addend),
        .result (aluResult)
    );

    resultCommit resultCommit_inst (
        .dec          (decBus.consumer),
        .commit       (commit),
        .aluResult    (aluResult),
        .valueZ       (valueZ),
        .dReadData    (dReadData),
        .dAddr        (dAddr),
        .dWriteData   (dWriteData),
        .regWriteData (regWriteData),
        .regWriteEn   (regWriteEn),
        .dataWe       (dataWe)
    );

    coreSequencer #(
        .RESET_VECTOR (RESET_VECTOR)
    ) coreSequencer_inst (
        .clk     (clk),
        .reset_n (reset_n),
        .en      (en),
        .illegal (decBus.illegal),
        .branch  (decBus.branch),
        .target  (regWriteData),                    // Jump takes the written value
        .pc      (iAddr),
        .execEn  (execEn),
        .commit  (commit),
        .halt    (halt)
    );

endmodule

`default_nettype wire
